// ==== bench/blit_fifo_stim.txt ====
# Pixel FIFO stimulus, counts in dots, data in hex, STALLS = refused cycles before accept
# mode M | clear | enq CNT DATA STALLS | enqr CNT STALLS | deq CNT SHIFT STALLS | wait N
# enqx CNT | deqx CNT (offer must be refused) | chk AVAIL FREE ENQ_RDY DEQ_RDY DEQ_VALID
chk 0 32 0 0 0
enq 16 e4e4a55a 0
enqr 10 0
enqx 8
chk 26 6 0 0 0
deq 12 0 0
enqr 16 0
deq 16 0 1
deq 14 0 0
enq 16 0123cdef 0
enq 16 fedc3210 0
deq 16 0 0
deq 10 6 0
deq 6 3 0
deqx 1
enq 16 5a5a5a5a 0
mode 1
chk 0 16 0 0 0
enq 8 13579bdf 0
enq 4 2468ace0 0
deq 6 2 0
deq 6 0 0
mode 2
enq 4 c3c3f00f 0
enq 4 9696a5a5 0
enqx 1
chk 8 0 0 0 0
deq 3 0 0
deq 3 1 0
deqx 4
chk 2 6 0 0 0
mode 3
chk 0 4 0 0 0
enq 2 abcd1234 0
enq 2 0f0ff0f0 0
deq 1 4 0
deq 2 0 0
enq 2 deadbeef 0
clear
chk 0 4 0 0 0
enq 2 77553311 0
deq 1 8 1
mode 0
enq 16 89abcdef 0
enq 8 fedcba98 0
wait 2
chk 24 8 0 0 0
clear
enqr 12 0
deq 8 5 1
chk 4 28 0 0 0

// ==== tb.f ====
src/blit_fifo_pkg.sv
src/blit_fifo_ctrl.sv
src/blit_fifo_write.sv
src/blit_fifo_store.sv
src/blit_fifo_read.sv
src/blit_fifo_top.sv
bench/tb_blit_fifo.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_blit_fifo
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_blit_fifo.sv ====
// Pixel FIFO testbench with clock, reset, stimulus player, reference model, checker and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_blit_fifo;

    logic                 CLK;
    logic                 RESET_n;
    logic                 mode_wr;
    logic                 clear;
    logic                 enq_valid;
    logic                 deq_valid;
    blit_fifo_pkg::clrm_t mode;
    logic [4:0]           enq_count;
    logic [4:0]           deq_count;
    logic [3:0]           deq_shift;
    logic [31:0]          enq_data;
    wire                  enq_ready;
    wire                  deq_ready;
    wire                  deq_data_valid;
    wire  [31:0]          deq_data;
    wire  [5:0]           avail_count;
    wire  [5:0]           free_count;

    logic [1:0]       model_q [$];   // Units in FIFO order including the word in flight
    logic [31:0]      model_word;    // Expected deq_data
    logic [31:0]      known_mask;    // Lanes the model can predict
    logic [8*128-1:0] lines [$];
    int               model_mode;
    int               errors;
    int               checks;
    int               n_lines;
    bit               loaded;
    string            test_name;

    blit_fifo_top #(.DEPTH_UNITS(32)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Offer a word and wait for the handshake; units go to the model at the accepting edge
    task automatic push_word(input int cnt, input logic [31:0] data, input int stalls);
        int waited = 0;
        int units;
        units     = cnt << model_mode;
        enq_valid = 1'b1;
        enq_count = 5'(cnt);
        enq_data  = data;
        @(negedge CLK);
        while (!enq_ready) begin
            waited++;
            @(negedge CLK);
        end
        @(posedge CLK);
        for (int i = 0; i < units; i++) begin
            model_q.push_back(data[31 - 2*i -: 2]);
        end
        #1;
        enq_valid = 1'b0;
        enq_count = '0;
        expect_eq("enq stalls", stalls, waited);
    endtask

    task automatic pop_word(input int cnt, input int shift, input int stalls);
        int waited = 0;
        int units;
        units     = cnt << model_mode;
        deq_valid = 1'b1;
        deq_count = 5'(cnt);
        deq_shift = 4'(shift);
        @(negedge CLK);
        while (!deq_ready) begin
            waited++;
            @(negedge CLK);
        end
        @(posedge CLK);
        // Window unit j lands in lane j+shift and lanes below the shift hold
        for (int k = shift; k < 16; k++) begin
            if (k - shift < units) begin
                model_word[31 - 2*k -: 2] = model_q.pop_front();
                known_mask[31 - 2*k -: 2] = 2'b11;
            end else begin
                known_mask[31 - 2*k -: 2] = 2'b00;   // Beyond the dequeued dots
            end
        end
        #1;
        deq_valid = 1'b0;
        deq_count = '0;
        @(negedge CLK);
        expect_eq("deq stalls", stalls, waited);
        expect_eq("deq_data_valid", 1, deq_data_valid);
        expect_eq("deq_data", model_word & known_mask, deq_data & known_mask);
        @(posedge CLK);
        #1;
    endtask

    task automatic offer_refused(input bit is_enq, input int cnt);
        enq_valid = is_enq;
        deq_valid = !is_enq;
        enq_count = is_enq ? 5'(cnt) : '0;
        deq_count = is_enq ? '0 : 5'(cnt);
        enq_data  = $urandom;
        @(negedge CLK);
        expect_eq("ready on refused offer", 0, is_enq ? enq_ready : deq_ready);
        @(posedge CLK);
        #1;
        enq_valid = 1'b0;
        deq_valid = 1'b0;
        enq_count = '0;
        deq_count = '0;
    endtask

    // Mode write or clear empties the FIFO
    task automatic pulse_ctrl(input bit is_mode, input int m);
        mode_wr = is_mode;
        clear   = !is_mode;
        mode    = blit_fifo_pkg::clrm_t'(m);
        @(posedge CLK);
        model_q.delete();
        if (is_mode) model_mode = m;
        #1;
        mode_wr = 1'b0;
        clear   = 1'b0;
    endtask

    task automatic check_status(input int avail, input int free, input int er, input int dr,
                                input int dv);
        @(negedge CLK);
        expect_eq("avail_count", avail, avail_count);
        expect_eq("free_count", free, free_count);
        expect_eq("enq_ready", er, enq_ready);
        expect_eq("deq_ready", dr, deq_ready);
        expect_eq("deq_data_valid", dv, deq_data_valid);
        @(posedge CLK);
        #1;
    endtask

    initial begin
        int               fd;
        int               a1;
        int               a2;
        int               a3;
        int               a4;
        int               a5;
        logic [8*128-1:0] line;
        logic [8*8-1:0]   op;
        logic [31:0]      data;
        void'($urandom(45));
        {errors, checks, model_mode, loaded} = '0;
        {mode_wr, clear, enq_valid, deq_valid, enq_count, deq_count, deq_shift} = '0;
        mode       = blit_fifo_pkg::CLRM_2BPP;
        enq_data   = '0;
        model_word = '0;
        known_mask = '0;
        test_name  = "setup";
        RESET_n    = 1'b0;
        fd = $fopen("bench/blit_fifo_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file bench/blit_fifo_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) lines.push_back(line);
            end
            $fclose(fd);
        end
        n_lines = lines.size();
        loaded  = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        RESET_n = 1'b1;
        foreach (lines[i]) begin
            test_name = $sformatf("line %0d", i + 1);
            {op, a1, a2, a3, a4, a5} = '0;
            void'($sscanf(lines[i], "%s", op));
            if (op == "enq") void'($sscanf(lines[i], "%s %d %h %d", op, a1, data, a3));
            else void'($sscanf(lines[i], "%s %d %d %d %d %d", op, a1, a2, a3, a4, a5));
            case (op)
                "mode":  pulse_ctrl(1'b1, a1);
                "clear": pulse_ctrl(1'b0, 0);
                "enq":   push_word(a1, data, a3);
                "enqr":  push_word(a1, $urandom, a2);
                "deq":   pop_word(a1, a2, a3);
                "enqx":  offer_refused(1'b1, a1);
                "deqx":  offer_refused(1'b0, a1);
                "wait": begin
                    repeat (a1) @(posedge CLK);
                    #1;
                end
                "chk":   check_status(a1, a2, a3, a4, a5);
                default: ;   // Comment or blank line
            endcase
        end
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog allows 20 cycles per stimulus line
    initial begin
        wait (loaded);
        repeat ((n_lines + 2) * 20) @(posedge CLK);
        $display("Timeout: the stimulus did not finish within %0d cycles", (n_lines + 2) * 20);
        $display("Errors: %0d in %0d checks", errors, checks);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/blit_fifo_top.sv ====
// Pixel FIFO top level joining control, write stage, unit store and read stage
`timescale 1ns/10ps
`default_nettype none

module blit_fifo_top #(
    parameter int DEPTH_UNITS = 32,
    localparam int OFS_W = $clog2(DEPTH_UNITS)
) (
    input  wire                                     CLK,
    input  wire                                     RESET_n,
    input  wire                                     mode_wr,
    input  wire blit_fifo_pkg::clrm_t               mode,
    input  wire                                     clear,
    input  wire                                     enq_valid,
    output wire                                     enq_ready,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      enq_count,
    input  wire [blit_fifo_pkg::WORD_W-1:0]         enq_data,
    input  wire                                     deq_valid,
    output wire                                     deq_ready,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      deq_count,
    input  wire [blit_fifo_pkg::LANE_W-1:0]         deq_shift,
    output wire [blit_fifo_pkg::WORD_W-1:0]         deq_data,
    output wire                                     deq_data_valid,
    output wire [blit_fifo_pkg::LEVEL_W-1:0]        avail_count,
    output wire [blit_fifo_pkg::LEVEL_W-1:0]        free_count
);

    blit_fifo_pkg::clrm_t                          clrm;
    wire                                           fifo_clear;
    wire                                           enq_fire;
    wire                                           deq_fire;
    wire [blit_fifo_pkg::LANES-1:0]                wr_mask;
    wire [OFS_W-1:0]                               wr_base;
    wire [blit_fifo_pkg::WORD_W-1:0]               wr_data;
    wire                                           wr_commit;
    wire [blit_fifo_pkg::DOT_CNT_W-1:0]            wr_commit_count;
    wire [DEPTH_UNITS*blit_fifo_pkg::UNIT_W-1:0]   contents;

    blit_fifo_ctrl #(.DEPTH_UNITS(DEPTH_UNITS)) u_ctrl (
        .CLK(CLK), .RESET_n(RESET_n),
        .mode_wr(mode_wr), .mode(mode), .clear(clear),
        .enq_valid(enq_valid), .enq_count(enq_count),
        .deq_valid(deq_valid), .deq_count(deq_count),
        .wr_commit(wr_commit), .wr_commit_count(wr_commit_count),
        .clrm(clrm), .fifo_clear(fifo_clear),
        .enq_ready(enq_ready), .deq_ready(deq_ready),
        .enq_fire(enq_fire), .deq_fire(deq_fire),
        .avail_count(avail_count), .free_count(free_count)
    );

    blit_fifo_write #(.DEPTH_UNITS(DEPTH_UNITS)) u_write (
        .CLK(CLK), .RESET_n(RESET_n),
        .clrm(clrm), .fifo_clear(fifo_clear),
        .enq_fire(enq_fire), .enq_count(enq_count), .enq_data(enq_data),
        .wr_mask(wr_mask), .wr_base(wr_base), .wr_data(wr_data),
        .wr_commit(wr_commit), .wr_commit_count(wr_commit_count)
    );

    blit_fifo_store #(.DEPTH_UNITS(DEPTH_UNITS)) u_store (
        .CLK(CLK),
        .wr_mask(wr_mask), .wr_base(wr_base), .wr_data(wr_data),
        .contents(contents)
    );

    blit_fifo_read #(.DEPTH_UNITS(DEPTH_UNITS)) u_read (
        .CLK(CLK), .RESET_n(RESET_n),
        .clrm(clrm), .fifo_clear(fifo_clear),
        .deq_fire(deq_fire), .deq_count(deq_count), .deq_shift(deq_shift),
        .contents(contents),
        .deq_data(deq_data), .deq_data_valid(deq_data_valid)
    );

endmodule

`default_nettype wire

// ==== src/blit_fifo_read.sv ====
// Read offset, lane-shifted gather from the store and dequeue output register
`timescale 1ns/10ps
`default_nettype none

module blit_fifo_read #(
    parameter int DEPTH_UNITS = 32,
    localparam int OFS_W = $clog2(DEPTH_UNITS)
) (
    input  wire                                             CLK,
    input  wire                                             RESET_n,
    input  wire blit_fifo_pkg::clrm_t                       clrm,
    input  wire                                             fifo_clear,
    input  wire                                             deq_fire,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]              deq_count,
    input  wire [blit_fifo_pkg::LANE_W-1:0]                 deq_shift,
    input  wire [DEPTH_UNITS*blit_fifo_pkg::UNIT_W-1:0]     contents,
    output logic [blit_fifo_pkg::WORD_W-1:0]                deq_data,
    output logic                                            deq_data_valid
);

    localparam int UNIT_W = blit_fifo_pkg::UNIT_W;
    localparam int WORD_W = blit_fifo_pkg::WORD_W;

    logic [blit_fifo_pkg::DOT_CNT_W-1:0] deq_units;
    logic [OFS_W-1:0]                    rd_ofs;
    logic [OFS_W-1:0]                    src;
    logic [WORD_W-1:0]                   gathered;

    assign deq_units = deq_count << blit_fifo_pkg::units_log2(clrm);

    // Output lane k takes window unit k-shift and lanes below the shift hold
    always_comb begin
        gathered = deq_data;
        src      = rd_ofs;
        for (int k = 0; k < blit_fifo_pkg::LANES; k++) begin
            src = rd_ofs + OFS_W'(k) - OFS_W'(deq_shift);
            if (k >= deq_shift) begin
                gathered[WORD_W - 1 - k*UNIT_W -: UNIT_W] = contents[src*UNIT_W +: UNIT_W];
            end
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            rd_ofs <= '0;
        end else if (fifo_clear) begin
            rd_ofs <= '0;
        end else if (deq_fire) begin
            rd_ofs <= rd_ofs + OFS_W'(deq_units);
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            deq_data       <= '0;
            deq_data_valid <= 1'b0;
        end else begin
            deq_data_valid <= deq_fire;    // One cycle per accepted dequeue
            if (deq_fire) begin
                deq_data <= gathered;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/blit_fifo_store.sv ====
// Register array of 2-bit units with sixteen wrapping write lanes
`timescale 1ns/10ps
`default_nettype none

module blit_fifo_store #(
    parameter int DEPTH_UNITS = 32,
    localparam int OFS_W = $clog2(DEPTH_UNITS)
) (
    input  wire                                             CLK,
    input  wire [blit_fifo_pkg::LANES-1:0]                  wr_mask,
    input  wire [OFS_W-1:0]                                 wr_base,
    input  wire [blit_fifo_pkg::WORD_W-1:0]                 wr_data,
    output logic [DEPTH_UNITS*blit_fifo_pkg::UNIT_W-1:0]    contents
);

    localparam int UNIT_W = blit_fifo_pkg::UNIT_W;
    localparam int WORD_W = blit_fifo_pkg::WORD_W;

    logic [UNIT_W-1:0] mem [DEPTH_UNITS];

    // Lane i carries the i-th unit from the top of the word
    always_ff @(posedge CLK) begin
        for (int i = 0; i < blit_fifo_pkg::LANES; i++) begin
            if (wr_mask[i]) begin
                mem[wr_base + OFS_W'(i)] <= wr_data[WORD_W - 1 - i*UNIT_W -: UNIT_W];
            end
        end
    end

    // Unit a sits at bits a*2 upward
    always_comb begin
        for (int a = 0; a < DEPTH_UNITS; a++) begin
            contents[a*UNIT_W +: UNIT_W] = mem[a];
        end
    end

endmodule

`default_nettype wire

// ==== src/blit_fifo_write.sv ====
// Enqueue stage with lane write mask, staged data word and write offset
`timescale 1ns/10ps
`default_nettype none

module blit_fifo_write #(
    parameter int DEPTH_UNITS = 32,
    localparam int OFS_W = $clog2(DEPTH_UNITS)
) (
    input  wire                                     CLK,
    input  wire                                     RESET_n,
    input  wire blit_fifo_pkg::clrm_t               clrm,
    input  wire                                     fifo_clear,
    input  wire                                     enq_fire,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      enq_count,
    input  wire [blit_fifo_pkg::WORD_W-1:0]         enq_data,
    output logic [blit_fifo_pkg::LANES-1:0]         wr_mask,
    output logic [OFS_W-1:0]                        wr_base,
    output logic [blit_fifo_pkg::WORD_W-1:0]        wr_data,
    output logic                                    wr_commit,
    output logic [blit_fifo_pkg::DOT_CNT_W-1:0]     wr_commit_count
);

    logic [blit_fifo_pkg::DOT_CNT_W-1:0] enq_units;
    logic [blit_fifo_pkg::DOT_CNT_W-1:0] stg_units;
    logic [blit_fifo_pkg::LANES-1:0]     enq_mask;

    assign enq_units = enq_count << blit_fifo_pkg::units_log2(clrm);

    // Lane 0 is the top unit of the word
    always_comb begin
        for (int i = 0; i < blit_fifo_pkg::LANES; i++) begin
            enq_mask[i] = (i < enq_units);
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_mask         <= '0;
            wr_commit       <= 1'b0;
            wr_commit_count <= '0;
            stg_units       <= '0;
        end else if (fifo_clear) begin
            wr_mask   <= '0;    // Staged word is dropped
            wr_commit <= 1'b0;
        end else begin
            wr_mask   <= enq_fire ? enq_mask : '0;
            wr_commit <= enq_fire;
            if (enq_fire) begin
                wr_commit_count <= enq_count;
                stg_units       <= enq_units;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) wr_data <= enq_data;
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_base <= '0;
        end else if (fifo_clear) begin
            wr_base <= '0;
        end else if (wr_commit) begin
            wr_base <= wr_base + OFS_W'(stg_units);    // Wraps at DEPTH_UNITS
        end
    end

endmodule

`default_nettype wire

// ==== src/blit_fifo_ctrl.sv ====
// Mode register, clear generation, occupancy counters and enqueue/dequeue handshake
`timescale 1ns/10ps
`default_nettype none

module blit_fifo_ctrl #(
    parameter int DEPTH_UNITS = 32
) (
    input  wire                                     CLK,
    input  wire                                     RESET_n,
    input  wire                                     mode_wr,
    input  wire blit_fifo_pkg::clrm_t               mode,
    input  wire                                     clear,
    input  wire                                     enq_valid,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      enq_count,
    input  wire                                     deq_valid,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      deq_count,
    input  wire                                     wr_commit,
    input  wire [blit_fifo_pkg::DOT_CNT_W-1:0]      wr_commit_count,
    output blit_fifo_pkg::clrm_t                    clrm,
    output logic                                    fifo_clear,
    output logic                                    enq_ready,
    output logic                                    deq_ready,
    output logic                                    enq_fire,
    output logic                                    deq_fire,
    output logic [blit_fifo_pkg::LEVEL_W-1:0]       avail_count,
    output logic [blit_fifo_pkg::LEVEL_W-1:0]       free_count
);

    localparam int LEVEL_W = blit_fifo_pkg::LEVEL_W;

    logic [LEVEL_W-1:0] resv_count;     // Dots of the word waiting to commit
    logic [LEVEL_W-1:0] capacity;
    logic [LEVEL_W-1:0] commit_dots;
    logic [LEVEL_W-1:0] deq_dots;
    logic [blit_fifo_pkg::DOT_CNT_W-1:0] mode_max;

    assign capacity   = LEVEL_W'(DEPTH_UNITS >> blit_fifo_pkg::units_log2(clrm));
    assign free_count = capacity - avail_count - resv_count;
    assign mode_max   = blit_fifo_pkg::max_dots(clrm);
    assign fifo_clear = clear | mode_wr;    // Mode change drops all stored dots

    assign enq_ready = !fifo_clear && (enq_count != '0) && (enq_count <= mode_max)
                       && (LEVEL_W'(enq_count) <= free_count);
    assign deq_ready = !fifo_clear && (deq_count != '0) && (deq_count <= mode_max)
                       && (LEVEL_W'(deq_count) <= avail_count);

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    assign commit_dots = wr_commit ? LEVEL_W'(wr_commit_count) : '0;
    assign deq_dots    = deq_fire ? LEVEL_W'(deq_count) : '0;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            clrm <= blit_fifo_pkg::CLRM_2BPP;
        end else if (mode_wr) begin
            clrm <= mode;
        end
    end

    // Only committed dots are readable; reserved ones already count against free
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            avail_count <= '0;
            resv_count  <= '0;
        end else if (fifo_clear) begin
            avail_count <= '0;
            resv_count  <= '0;
        end else begin
            avail_count <= avail_count + commit_dots - deq_dots;
            resv_count  <= enq_fire ? LEVEL_W'(enq_count) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/blit_fifo_pkg.sv ====
// Color mode type, word and count widths, per-mode unit and dot helpers
`default_nettype none

package blit_fifo_pkg;

    typedef enum logic [1:0] {
        CLRM_2BPP  = 2'd0,
        CLRM_4BPP  = 2'd1,
        CLRM_8BPP  = 2'd2,
        CLRM_16BPP = 2'd3
    } clrm_t;

    localparam int UNIT_W    = 2;   // One store unit is a 2bpp dot
    localparam int LANES     = 16;
    localparam int WORD_W    = UNIT_W * LANES;
    localparam int DOT_CNT_W = 5;   // 0 to 16 dots
    localparam int LANE_W    = 4;
    localparam int LEVEL_W   = 6;

    // Units per dot, as a shift amount
    function automatic logic [1:0] units_log2(input clrm_t m);
        case (m)
            CLRM_2BPP: return 2'd0;
            CLRM_4BPP: return 2'd1;
            CLRM_8BPP: return 2'd2;
            default:   return 2'd3;
        endcase
    endfunction

    function automatic logic [DOT_CNT_W-1:0] max_dots(input clrm_t m);
        return DOT_CNT_W'(LANES >> units_log2(m));
    endfunction

endpackage

`default_nettype wire
